// File: bench/l1_cache_asserts.sv
//##############################
// l1 cache bus protocol checks
//##############################
`timescale 1ns/100ps

module l1_cache_asserts import l1_cache_pkg::*; (
    input logic         CLK,
    input logic         nRST,
    input logic         mem_ren,
    input logic         mem_wen,
    input word_t        mem_addr,
    input logic         mem_busy,
    input logic         proc_busy,
    input cache_state_t state
);

    // one kind of access on the memory bus at a time
    one_mem_access: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high in the same cycle");

    stalled_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr))
        else $error("mem_addr changed while memory was busy");

    // only lookup may answer the processor
    busy_outside_lookup: assert property (@(posedge CLK) disable iff (!nRST)
        (state != LOOKUP) |-> proc_busy)
        else $error("proc_busy low outside the lookup state");

endmodule

bind l1_cache l1_cache_asserts i_l1_cache_asserts (
    .CLK      (CLK),
    .nRST     (nRST),
    .mem_ren  (mem_ren),
    .mem_wen  (mem_wen),
    .mem_addr (mem_addr),
    .mem_busy (mem_busy),
    .proc_busy(proc_busy),
    .state    (i_cache_fsm.state)
);

// File: bench/tb_clock.sv
//##############################
// testbench clock and reset
//##############################
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 nRST = 1'b1;   // released just after the edge
    end

endmodule

// File: bench/tb_l1_cache.sv
//##############################
// l1 cache testbench with memory
// model and reference compare
//##############################
`timescale 1ns/100ps
`include "l1_defs.svh"

module tb_l1_cache import l1_cache_pkg::*; ();

    localparam int SETTLE  = 2;     // drive delay after the rising edge
    localparam int TIMEOUT = 100;   // cycles per wait
    localparam int N_ROWS  = 33;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_MEM} op_t;   // OP_MEM checks backing store

    typedef struct packed {
        op_t      op;
        word_t    addr;
        word_t    wdata;
        byte_en_t be;
        logic     mem_use;   // memory bus expected during the op
    } row_t;

    logic     CLK, nRST;
    logic     proc_ren, proc_wen, proc_busy;
    word_t    proc_addr, proc_wdata, proc_rdata;
    byte_en_t proc_byte_en;
    logic     mem_ren, mem_wen, mem_busy;
    word_t    mem_addr, mem_wdata, mem_rdata;
    byte_en_t mem_byte_en;

    word_t  mem [word_t];       // what the cache sees behind it
    word_t  ref_mem [word_t];   // flat memory as the processor sees it
    integer seed = 32'h645469b5;

    row_t rows [N_ROWS] = '{
        '{OP_RD,  32'h0000_0040, 32'h0000_0000, 4'h0, 1'b1},  // cold miss
        '{OP_RD,  32'h0000_0044, 32'h0000_0000, 4'h0, 1'b0},  // same block
        '{OP_WR,  32'h0000_0040, 32'hAABB_CCDD, 4'h1, 1'b0},
        '{OP_WR,  32'h0000_0044, 32'h1122_3344, 4'hC, 1'b0},
        '{OP_WR,  32'h0000_0040, 32'h5566_7788, 4'h6, 1'b0},
        '{OP_RD,  32'h0000_0040, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_RD,  32'h0000_0044, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_RD,  32'h0000_00C0, 32'h0000_0000, 4'h0, 1'b1},  // evicts dirty set 8
        '{OP_MEM, 32'h0000_0040, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_MEM, 32'h0000_0044, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_RD,  32'h0000_0040, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_RD,  32'hF000_0000, 32'h0000_0000, 4'h0, 1'b1},  // first uncached word
        '{OP_WR,  32'hF000_0000, 32'hCAFE_F00D, 4'hF, 1'b1},
        '{OP_RD,  32'hF000_0000, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_RD,  32'hF000_0000, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_WR,  32'hF000_0014, 32'h1234_5678, 4'h3, 1'b1},
        '{OP_RD,  32'hF000_0014, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_MEM, 32'hF000_0014, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_WR,  32'h0000_0108, 32'hDEAD_BEEF, 4'hF, 1'b1},  // write miss
        '{OP_RD,  32'h0000_010C, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_RD,  32'h0000_0108, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_WR,  32'h0000_0188, 32'h9900_0000, 4'h8, 1'b1},
        '{OP_RD,  32'h0000_0108, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_RD,  32'h0000_0188, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_MEM, 32'h0000_0188, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_RD,  32'h0000_01F8, 32'h0000_0000, 4'h0, 1'b1},  // last set
        '{OP_RD,  32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1},  // first set
        '{OP_WR,  32'h0000_0004, 32'hA5A5_A5A5, 4'h5, 1'b0},
        '{OP_RD,  32'h0000_0004, 32'h0000_0000, 4'h0, 1'b0},
        '{OP_RD,  32'hEFFF_FFF8, 32'h0000_0000, 4'h0, 1'b1},  // just below window
        '{OP_RD,  32'hEFFF_FFFC, 32'h0000_0000, 4'h0, 1'b0},  // still cached
        '{OP_RD,  32'hFFFF_FFFC, 32'h0000_0000, 4'h0, 1'b1},
        '{OP_RD,  32'h0000_01F8, 32'h0000_0000, 4'h0, 1'b1}
    };

    tb_clock i_tb_clock (.CLK(CLK), .nRST(nRST));

    l1_cache i_l1_cache (.*);

    function automatic word_t word_key(word_t a);
        return {a[31:2], 2'b00};
    endfunction

    // contents of never written words
    function automatic word_t fill_word(word_t a);
        return {a[15:0], a[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    function automatic word_t backing_read(word_t a);
        return mem.exists(word_key(a)) ? mem[word_key(a)] : fill_word(word_key(a));
    endfunction

    function automatic word_t ref_read(word_t a);
        return ref_mem.exists(word_key(a)) ? ref_mem[word_key(a)] : fill_word(word_key(a));
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, byte_en_t be);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_timeout(string what);
        $display("timed out at %0t waiting for %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // entered at a falling edge and left at the one with proc_busy low
    task automatic wait_for_done(output logic touched);
        int n;
        n = 0;
        touched = mem_ren || mem_wen;
        while (proc_busy) begin
            n++;
            if (n > TIMEOUT) report_timeout("proc_busy to fall");
            @(negedge CLK);
            touched = touched || mem_ren || mem_wen;
        end
    endtask

    task automatic check_sweep_cycle();
        check_bit("proc_busy", proc_busy, 1'b1);
        check_bit("mem_ren", mem_ren, 1'b0);
        check_bit("mem_wen", mem_wen, 1'b0);
    endtask

    // sweep must last exactly one cycle per set
    task automatic watch_reset_sweep();
        int    n;
        logic  touched;
        word_t expected;
        n = 0;
        @(negedge CLK);
        while (!nRST) begin
            n++;
            if (n > TIMEOUT) report_timeout("reset release");
            @(negedge CLK);
        end
        check_sweep_cycle();
        @(posedge CLK);
        #SETTLE;
        expected  = ref_read(32'hF000_0100);
        proc_ren  = 1'b1;   // held through the sweep
        proc_addr = 32'hF000_0100;
        repeat (`L1_SETS - 1) begin
            @(negedge CLK);
            check_sweep_cycle();
        end
        @(negedge CLK);
        check_bit("mem_ren", mem_ren, 1'b1);
        wait_for_done(touched);
        check_word("proc_rdata", proc_rdata, expected);
    endtask

    task automatic run_row(row_t r);
        logic  touched;
        word_t expected;
        @(posedge CLK);
        #SETTLE;
        if (r.op == OP_MEM) begin
            proc_ren = 1'b0;
            proc_wen = 1'b0;
            @(negedge CLK);   // model applies its writes after the edge
            check_word($sformatf("mem[%h]", r.addr), backing_read(r.addr), ref_read(r.addr));
        end else begin
            expected     = ref_read(r.addr);
            proc_ren     = (r.op == OP_RD);
            proc_wen     = (r.op == OP_WR);
            proc_addr    = r.addr;
            proc_wdata   = r.wdata;
            proc_byte_en = r.be;
            @(negedge CLK);
            wait_for_done(touched);
            if (r.op == OP_RD) begin
                check_word("proc_rdata", proc_rdata, expected);
            end else begin
                ref_mem[word_key(r.addr)] = merge_bytes(expected, r.wdata, r.be);
            end
            check_bit("memory bus used", touched, r.mem_use);
        end
    endtask

    // word memory busy for 1 + random 0..3 cycles per word
    initial begin : memory_model
        logic     c_req, c_wen, c_busy, started;
        word_t    c_addr, c_wdata;
        byte_en_t c_be;
        int       wait_left;
        mem_busy  = 1'b1;
        mem_rdata = '0;
        started   = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge CLK);
            c_req   = mem_ren || mem_wen;
            c_wen   = mem_wen;
            c_busy  = mem_busy;
            c_addr  = mem_addr;
            c_wdata = mem_wdata;
            c_be    = mem_byte_en;
            @(posedge CLK);
            #SETTLE;
            if (c_req && !c_busy) begin
                if (c_wen) begin
                    mem[word_key(c_addr)] = merge_bytes(backing_read(c_addr), c_wdata, c_be);
                end
                mem_busy = 1'b1;   // word finished at this edge
                started  = 1'b0;
            end else if (c_req) begin
                if (!started) begin
                    started   = 1'b1;
                    wait_left = $random(seed) & 3;
                end else if (wait_left > 0) begin
                    wait_left--;
                end
                if (wait_left == 0) begin
                    mem_busy  = 1'b0;
                    mem_rdata = backing_read(c_addr);
                end
            end else begin
                mem_busy = 1'b1;
                started  = 1'b0;
            end
        end
    end

    initial begin : stimulus
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        watch_reset_sweep();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        @(posedge CLK);
        #SETTLE;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        $display("No errors");
        $finish;
    end

endmodule

// File: logic/cache_fsm.sv
//##############################
// cache_fsm: controller for hits,
// misses, sweep and memory bus
//##############################
`timescale 1ns/100ps
`include "l1_defs.svh"

module cache_fsm import l1_cache_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    store_if.ctrl        ctl,
    // processor side
    input  logic         proc_ren,
    input  logic         proc_wen,
    input  word_t        proc_addr,
    input  word_t        proc_wdata,
    input  byte_en_t     proc_byte_en,
    output word_t        proc_rdata,
    output logic         proc_busy,
    // memory side
    output logic         mem_ren,
    output logic         mem_wen,
    output word_t        mem_addr,
    output word_t        mem_wdata,
    output byte_en_t     mem_byte_en,
    input  word_t        mem_rdata,
    input  logic         mem_busy,
    // from hit_lookup
    input  logic         hit,
    input  logic         pass_through,
    input  logic         victim_dirty,
    input  word_t        hit_rdata,
    input  cache_frame_t wr_frame,
    input  cache_frame_t wr_mask
);

    cache_state_t                state, next_state;
    logic [`L1_OFFSET_BITS-1:0]  word_cnt, next_word_cnt;
    logic [`L1_SET_BITS-1:0]     sweep_idx;
    cache_addr_u                 mem_q, next_mem_q;   // block address on the memory bus
    cache_addr_u                 req;
    logic                        req_any;
    logic                        last_word;

    assign req.raw   = proc_addr;
    assign req_any   = proc_ren || proc_wen;
    assign last_word = (word_cnt == `L1_OFFSET_BITS'(`L1_BLOCK_WORDS - 1));

    // sweep walks the sets, otherwise the request picks the set
    assign ctl.sel = (state == INIT) ? sweep_idx : req.fields.set_idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            word_cnt  <= '0;
            sweep_idx <= '0;
            mem_q     <= '0;
        end else begin
            state     <= next_state;
            word_cnt  <= next_word_cnt;
            mem_q     <= next_mem_q;
            if (state == INIT) begin
                sweep_idx <= sweep_idx + 1'b1;
            end
        end
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        next_mem_q    = mem_q;

        ctl.wen    = 1'b0;
        ctl.wframe = '0;
        ctl.wmask  = '1;

        proc_busy   = 1'b1;
        proc_rdata  = hit_rdata;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = mem_q.raw;
        mem_wdata   = ctl.rframe.data[word_cnt];
        mem_byte_en = '1;     // whole words for block moves

        case (state)
            INIT: begin
                ctl.wen   = 1'b1;   // zero the whole frame
                ctl.wmask = '0;
                if (sweep_idx == `L1_SET_BITS'(`L1_SETS - 1)) begin
                    next_state = LOOKUP;
                end
            end

            LOOKUP: begin
                if (pass_through && req_any) begin
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_wdata   = proc_wdata;
                    mem_byte_en = proc_byte_en;   // memory applies the lanes
                    proc_busy   = mem_busy;
                    proc_rdata  = mem_rdata;
                end else if (hit && req_any) begin
                    proc_busy = 1'b0;
                    if (proc_wen) begin
                        ctl.wen    = 1'b1;
                        ctl.wframe = wr_frame;
                        ctl.wmask  = wr_mask;
                    end
                end else if (req_any) begin
                    // miss: victim block first if it is dirty
                    next_word_cnt                = '0;
                    next_mem_q.fields.set_idx    = req.fields.set_idx;
                    next_mem_q.fields.offset     = '0;
                    next_mem_q.fields.byte_sel   = 2'b00;
                    if (victim_dirty) begin
                        next_mem_q.fields.tag = ctl.rframe.tag;
                        next_state            = WRITEBACK;
                    end else begin
                        next_mem_q.fields.tag = req.fields.tag;
                        next_state            = FETCH;
                    end
                end
            end

            WRITEBACK: begin
                mem_wen = 1'b1;
                if (!mem_busy) begin
                    next_word_cnt  = word_cnt + 1'b1;
                    next_mem_q.raw = mem_q.raw + 32'd4;
                    if (last_word) begin
                        // block is clean in memory now
                        ctl.wen                  = 1'b1;
                        ctl.wmask.valid          = 1'b0;
                        ctl.wmask.dirty          = 1'b0;
                        next_mem_q.fields.tag    = req.fields.tag;
                        next_mem_q.fields.offset = '0;
                        next_mem_q.fields.set_idx = req.fields.set_idx;
                        next_state               = FETCH;
                    end
                end
            end

            FETCH: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    ctl.wen                      = 1'b1;
                    ctl.wframe.data[word_cnt]    = mem_rdata;
                    ctl.wmask.data[word_cnt]     = '0;
                    next_word_cnt                = word_cnt + 1'b1;
                    next_mem_q.raw               = mem_q.raw + 32'd4;
                    if (last_word) begin
                        ctl.wframe.valid = 1'b1;
                        ctl.wframe.tag   = req.fields.tag;
                        ctl.wmask.valid  = 1'b0;
                        ctl.wmask.dirty  = 1'b0;   // fresh block is clean
                        ctl.wmask.tag    = '0;
                        next_state       = LOOKUP;
                    end
                end
            end

            default: next_state = INIT;
        endcase
    end

endmodule

// File: logic/cache_store.sv
//##############################
// cache_store: frame array with
// async read, masked write
//##############################
`timescale 1ns/100ps
`include "l1_defs.svh"

module cache_store import l1_cache_pkg::*; (
    input logic CLK,
    input logic nRST,
    store_if.store st
);

    cache_frame_t frames [`L1_SETS];
    cache_frame_t merged;

    assign st.rframe = frames[st.sel];

    // masked bits keep their old value
    assign merged = (frames[st.sel] & st.wmask) | (st.wframe & ~st.wmask);

    // no writes land while reset is held, the sweep clears after
    always_ff @(posedge CLK) begin
        if (nRST && st.wen) begin
            frames[st.sel] <= merged;
        end
    end

endmodule

// File: logic/hit_lookup.sv
//##############################
// hit_lookup: tag compare, word
// select and write-hit mask
//##############################
`timescale 1ns/100ps
`include "l1_defs.svh"

module hit_lookup import l1_cache_pkg::*; (
    store_if.lookup lk,
    input  word_t        proc_addr,
    input  word_t        proc_wdata,
    input  byte_en_t     proc_byte_en,
    output logic         hit,
    output logic         pass_through,
    output logic         victim_dirty,
    output word_t        hit_rdata,
    output cache_frame_t wr_frame,
    output cache_frame_t wr_mask
);

    cache_addr_u req;

    assign req.raw = proc_addr;

    // uncached window compares the whole word
    assign pass_through = (req.raw >= `L1_NONCACHE_START);

    assign hit = !pass_through && lk.rframe.valid &&
                 (lk.rframe.tag == req.fields.tag);

    // only a valid dirty frame needs writing back
    assign victim_dirty = lk.rframe.valid && lk.rframe.dirty;

    assign hit_rdata = lk.rframe.data[req.fields.offset];

    // write hit: new bytes into the addressed word, mark dirty
    always_comb begin
        wr_frame = '0;
        wr_mask  = '1;

        wr_frame.dirty                   = 1'b1;
        wr_mask.dirty                    = 1'b0;
        wr_frame.data[req.fields.offset] = proc_wdata;

        for (int b = 0; b < 4; b++) begin
            if (proc_byte_en[b]) begin
                wr_mask.data[req.fields.offset][8*b +: 8] = 8'h00;  // open this lane
            end
        end
    end

endmodule

// File: logic/l1_cache.sv
//##############################
// l1_cache: direct mapped write
// back data cache top level
//##############################
`timescale 1ns/100ps

module l1_cache import l1_cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    // processor side
    input  logic     proc_ren,
    input  logic     proc_wen,
    input  word_t    proc_addr,
    input  word_t    proc_wdata,
    input  byte_en_t proc_byte_en,
    output word_t    proc_rdata,
    output logic     proc_busy,
    // memory side
    output logic     mem_ren,
    output logic     mem_wen,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output byte_en_t mem_byte_en,
    input  word_t    mem_rdata,
    input  logic     mem_busy
);

    logic         hit;
    logic         pass_through;
    logic         victim_dirty;
    word_t        hit_rdata;
    cache_frame_t wr_frame;
    cache_frame_t wr_mask;

    store_if st_if ();

    cache_store i_cache_store (
        .CLK (CLK),
        .nRST(nRST),
        .st  (st_if.store)
    );

    hit_lookup i_hit_lookup (
        .lk          (st_if.lookup),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .proc_byte_en(proc_byte_en),
        .hit         (hit),
        .pass_through(pass_through),
        .victim_dirty(victim_dirty),
        .hit_rdata   (hit_rdata),
        .wr_frame    (wr_frame),
        .wr_mask     (wr_mask)
    );

    cache_fsm i_cache_fsm (
        .CLK         (CLK),
        .nRST        (nRST),
        .ctl         (st_if.ctrl),
        .proc_ren    (proc_ren),
        .proc_wen    (proc_wen),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .proc_byte_en(proc_byte_en),
        .proc_rdata  (proc_rdata),
        .proc_busy   (proc_busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .hit         (hit),
        .pass_through(pass_through),
        .victim_dirty(victim_dirty),
        .hit_rdata   (hit_rdata),
        .wr_frame    (wr_frame),
        .wr_mask     (wr_mask)
    );

endmodule

// File: logic/l1_cache_pkg.sv
//##############################
// l1 cache shared types
//##############################
`include "l1_defs.svh"

package l1_cache_pkg;

    typedef logic [`L1_WORD_BITS-1:0] word_t;
    typedef logic [3:0]               byte_en_t;  // one per byte lane

    typedef struct packed {
        logic [`L1_TAG_BITS-1:0]    tag;
        logic [`L1_SET_BITS-1:0]    set_idx;
        logic [`L1_OFFSET_BITS-1:0] offset;    // word within block
        logic [1:0]                 byte_sel;
    } cache_addr_t;

    // same address seen as a plain word or split into fields
    typedef union packed {
        word_t       raw;
        cache_addr_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic                              valid;
        logic                              dirty;
        logic [`L1_TAG_BITS-1:0]           tag;
        word_t [`L1_BLOCK_WORDS-1:0]       data;
    } cache_frame_t;

    typedef enum logic [1:0] {
        INIT,       // reset sweep
        LOOKUP,
        WRITEBACK,
        FETCH
    } cache_state_t;

endpackage

// File: logic/l1_defs.svh
//##############################
// l1 data cache geometry and
// address window constants
//##############################
`ifndef L1_DEFS_SVH
`define L1_DEFS_SVH

// data word width
`define L1_WORD_BITS      32

// direct mapped, one frame per set
`define L1_SETS           16
`define L1_SET_BITS       4

// block size in words
`define L1_BLOCK_WORDS    2
`define L1_OFFSET_BITS    1

// what is left of the address after set, word offset and 2 byte bits
`define L1_TAG_BITS       (`L1_WORD_BITS - `L1_SET_BITS - `L1_OFFSET_BITS - 2)

// everything from here up bypasses the cache
`define L1_NONCACHE_START 32'hF000_0000

`endif

// File: logic/store_if.sv
//##############################
// frame store port shared by
// controller, store and lookup
//##############################
`timescale 1ns/100ps
`include "l1_defs.svh"

interface store_if import l1_cache_pkg::*; ();

    logic [`L1_SET_BITS-1:0] sel;
    logic                    wen;
    cache_frame_t            wframe;
    cache_frame_t            wmask;   // set bit keeps the stored bit
    cache_frame_t            rframe;  // selected set, combinational

    modport ctrl   (output sel, wen, wframe, wmask, input rframe);
    modport store  (input sel, wen, wframe, wmask, output rframe);
    modport lookup (input rframe);

endinterface

// File: run_sim.sh
#!/bin/sh
# build the l1 cache testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_cache -f sources.f -o tb_l1_cache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_l1_cache 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
echo "pass line missing from simulation output"
exit 1

// File: sources.f
+incdir+logic
logic/l1_cache_pkg.sv
logic/store_if.sv
logic/cache_store.sv
logic/hit_lookup.sv
logic/cache_fsm.sv
logic/l1_cache.sv
bench/tb_clock.sv
bench/l1_cache_asserts.sv
bench/tb_l1_cache.sv
